// ==== design/pdp8Exec_consts.svh ====
// PDP-8 execution unit constants for bus widths, start address and stall lengths
`ifndef PDP8EXEC_CONSTS_SVH
`define PDP8EXEC_CONSTS_SVH

// Address and data word widths
`define ADDR_WIDTH 12
`define DATA_WIDTH 12

// PC value expected right after reset (octal 200)
`define START_ADDRESS 12'o200

// Stall length of each instruction class
// counted in clock edges after the accept edge
`define CYCLES_ANDTAD 4
`define CYCLES_ISZ    5
`define CYCLES_DCAJMS 3
`define CYCLES_JMP    3
`define CYCLES_OP7    3

`endif

// ==== design/pdp8ExecPkg.sv ====
// PDP-8 execution unit types for decoded opcodes and sequencer steps
`include "pdp8Exec_consts.svh"

package pdp8ExecPkg;

    // Decoded memory-reference instruction
    // One-hot opcode bits, then the direct operand address
    typedef struct packed {
        logic                   opAnd;
        logic                   opTad;
        logic                   opIsz;
        logic                   opDca;
        logic                   opJms;
        logic                   opJmp;
        logic [`ADDR_WIDTH-1:0] memAddr;
    } memOpcodeT;

    // Decoded operate-group instruction
    typedef struct packed {
        logic nop;
        logic claCll;
    } op7OpcodeT;

    // Sequencer steps
    // idle      no instruction held, stall low
    // read      read request on the bus
    // readWait  read data on the bus, also the decode slot of non-memory ops
    // execute   accumulator update
    // write     write request on the bus
    // finish    last stall cycle, PC loads on the following edge
    typedef enum logic [2:0] {
        idle,
        read,
        readWait,
        execute,
        write,
        finish
    } execStepT;

endpackage

// ==== design/execSequencer.sv ====
// Execution sequencer that accepts instructions, steps each one and owns stall and the PC
`timescale 1ns/1ps
`include "pdp8Exec_consts.svh"

module execSequencer import pdp8ExecPkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [`ADDR_WIDTH-1:0] baseAddr,
    input  memOpcodeT              memOpcode,
    input  op7OpcodeT              op7Opcode,
    input  logic                   iszSkip,
    output logic                   stall,
    output logic [`ADDR_WIDTH-1:0] pcValue,
    output logic                   illegalInstr,
    output execStepT               step,
    output memOpcodeT              curMem,
    output op7OpcodeT              curOp7
);

    logic [7:0]             opBits;
    logic                   instrPresent;
    logic                   instrLegal;
    logic                   accept;
    execStepT               firstStep;
    logic [`ADDR_WIDTH-1:0] nextPc;

    // All opcode bits of both groups, legal only when exactly one is set
    assign opBits = {memOpcode.opAnd, memOpcode.opTad, memOpcode.opIsz,
                     memOpcode.opDca, memOpcode.opJms, memOpcode.opJmp,
                     op7Opcode.nop, op7Opcode.claCll};
    assign instrPresent = |opBits;
    assign instrLegal   = $onehot(opBits);
    assign accept       = !stall && instrLegal;

    assign stall = (step != idle);

    // Entry step of the sequence, chosen from the incoming opcode
    always_comb begin
        if (memOpcode.opAnd || memOpcode.opTad || memOpcode.opIsz) begin
            firstStep = read;
        end else if (memOpcode.opDca || memOpcode.opJms) begin
            firstStep = write;
        end else begin
            // JMP and operate group only wait one cycle before execute
            firstStep = readWait;
        end
    end

    always_comb begin
        nextPc = pcValue + `ADDR_WIDTH'(1);
        if (curMem.opJmp) begin
            nextPc = curMem.memAddr;
        end else if (curMem.opJms) begin
            nextPc = curMem.memAddr + `ADDR_WIDTH'(1);
        end else if (curMem.opIsz && iszSkip) begin
            nextPc = pcValue + `ADDR_WIDTH'(2);
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            step         <= idle;
            curMem       <= '0;
            curOp7       <= '0;
            pcValue      <= baseAddr;
            illegalInstr <= 1'b0;
        end else begin
            // One pulse per edge that sees a multi-hot opcode while idle
            illegalInstr <= !stall && instrPresent && !instrLegal;

            case (step)
                idle: begin
                    if (accept) begin
                        curMem <= memOpcode;
                        curOp7 <= op7Opcode;
                        step   <= firstStep;
                    end
                end
                read:     step <= readWait;
                readWait: step <= execute;
                execute:  step <= curMem.opIsz ? write : finish;
                write: begin
                    // DCA and JMS write first, ISZ writes after its execute
                    step <= (curMem.opDca || curMem.opJms) ? execute : finish;
                end
                finish: begin
                    step    <= idle;
                    pcValue <= nextPc;
                end
                default: step <= idle;
            endcase
        end
    end

    // Decoder keeps its opcode lines at zero while the unit is busy
    opcodeHoldA: assert property (@(posedge clk) disable iff (!reset_n)
        stall |-> (memOpcode == '0) && (op7Opcode == '0))
        else $error("opcode input driven while stall is high");

    // Stall spans exactly the class cycle count after the accept edge
    stallLengthA: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(stall) |->
            (((curMem.opAnd || curMem.opTad) && $past(accept, `CYCLES_ANDTAD + 1)) ||
             (curMem.opIsz && $past(accept, `CYCLES_ISZ + 1)) ||
             ((curMem.opDca || curMem.opJms) && $past(accept, `CYCLES_DCAJMS + 1)) ||
             (curMem.opJmp && $past(accept, `CYCLES_JMP + 1)) ||
             ((curOp7.nop || curOp7.claCll) && $past(accept, `CYCLES_OP7 + 1))))
        else $error("stall length does not match instruction class");

    // First PC out of reset is the standard program start
    startAddrA: assert property (@(posedge clk)
        $rose(reset_n) |-> pcValue == `START_ADDRESS)
        else $error("PC after reset is not the start address");

endmodule

// ==== design/accumulatorUnit.sv ====
// Accumulator datapath holding AC and link, applying AND, TAD, DCA clear and CLA_CLL
`timescale 1ns/1ps
`include "pdp8Exec_consts.svh"

module accumulatorUnit import pdp8ExecPkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  execStepT               step,
    input  memOpcodeT              curMem,
    input  op7OpcodeT              curOp7,
    input  logic [`DATA_WIDTH-1:0] rdWord,
    output logic [`DATA_WIDTH-1:0] accValue,
    output logic                   linkValue
);

    logic [`DATA_WIDTH:0] tadSum;

    // Extra bit holds the carry out of TAD
    assign tadSum = {1'b0, accValue} + {1'b0, rdWord};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            accValue  <= '0;
            linkValue <= 1'b0;
        end else if (step == execute) begin
            if (curMem.opAnd) begin
                accValue <= accValue & rdWord;
            end else if (curMem.opTad) begin
                accValue  <= tadSum[`DATA_WIDTH-1:0];
                // Carry out complements the link
                linkValue <= linkValue ^ tadSum[`DATA_WIDTH];
            end else if (curMem.opDca) begin
                // Word already went out on the write bus in the step before
                accValue <= '0;
            end else if (curOp7.claCll) begin
                accValue  <= '0;
                linkValue <= 1'b0;
            end
        end
    end

    // AC and link only move on the execute step of the sequencer
    accStableA: assert property (@(posedge clk) disable iff (!reset_n)
        (step != execute) |=> $stable(accValue) && $stable(linkValue))
        else $error("accumulator changed outside the execute step");

endmodule

// ==== design/memoryAccess.sv ====
// Memory access port issuing reads and writes, capturing read data and forming ISZ results
`timescale 1ns/1ps
`include "pdp8Exec_consts.svh"

module memoryAccess import pdp8ExecPkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  execStepT               step,
    input  memOpcodeT              curMem,
    input  logic [`ADDR_WIDTH-1:0] pcValue,
    input  logic [`DATA_WIDTH-1:0] accValue,
    input  logic [`DATA_WIDTH-1:0] rdData,
    output logic                   rdReq,
    output logic [`ADDR_WIDTH-1:0] rdAddr,
    output logic                   wrReq,
    output logic [`ADDR_WIDTH-1:0] wrAddr,
    output logic [`DATA_WIDTH-1:0] wrData,
    output logic [`DATA_WIDTH-1:0] rdWord,
    output logic                   iszSkip
);

    logic                   isRead;
    logic [`DATA_WIDTH-1:0] incWord;

    assign isRead = curMem.opAnd || curMem.opTad || curMem.opIsz;

    // Requests follow the sequencer step directly, address is the latched operand
    assign rdReq  = (step == read);
    assign rdAddr = curMem.memAddr;
    assign wrReq  = (step == write);
    assign wrAddr = curMem.memAddr;

    // ISZ increment, a wrap to zero skips the next instruction
    assign incWord = rdWord + `DATA_WIDTH'(1);
    assign iszSkip = (incWord == '0);

    always_comb begin
        if (curMem.opIsz) begin
            wrData = incWord;
        end else if (curMem.opJms) begin
            // Return address
            wrData = pcValue + `ADDR_WIDTH'(1);
        end else begin
            wrData = accValue;
        end
    end

    // Memory answers one cycle after the request
    always_ff @(posedge clk) begin
        if (step == readWait && isRead) begin
            rdWord <= rdData;
        end
    end

    rdWrExclusiveA: assert property (@(posedge clk) disable iff (!reset_n)
        !(rdReq && wrReq))
        else $error("read and write request in the same cycle");

endmodule

// ==== design/execUnitTop.sv ====
// PDP-8 execution unit top connecting the sequencer, accumulator datapath and memory port
`timescale 1ns/1ps
`include "pdp8Exec_consts.svh"

module execUnitTop import pdp8ExecPkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [`ADDR_WIDTH-1:0] baseAddr,
    input  memOpcodeT              memOpcode,
    input  op7OpcodeT              op7Opcode,
    input  logic [`DATA_WIDTH-1:0] rdData,
    output logic                   stall,
    output logic [`ADDR_WIDTH-1:0] pcValue,
    output logic                   illegalInstr,
    output logic                   rdReq,
    output logic [`ADDR_WIDTH-1:0] rdAddr,
    output logic                   wrReq,
    output logic [`ADDR_WIDTH-1:0] wrAddr,
    output logic [`DATA_WIDTH-1:0] wrData,
    output logic [`DATA_WIDTH-1:0] accValue,
    output logic                   linkValue
);

    execStepT               step;
    memOpcodeT              curMem;
    op7OpcodeT              curOp7;
    logic [`DATA_WIDTH-1:0] rdWord;
    logic                   iszSkip;

    execSequencer sequencer_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .baseAddr     (baseAddr),
        .memOpcode    (memOpcode),
        .op7Opcode    (op7Opcode),
        .iszSkip      (iszSkip),
        .stall        (stall),
        .pcValue      (pcValue),
        .illegalInstr (illegalInstr),
        .step         (step),
        .curMem       (curMem),
        .curOp7       (curOp7)
    );

    accumulatorUnit accumulator_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .step      (step),
        .curMem    (curMem),
        .curOp7    (curOp7),
        .rdWord    (rdWord),
        .accValue  (accValue),
        .linkValue (linkValue)
    );

    memoryAccess memPort_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .step     (step),
        .curMem   (curMem),
        .pcValue  (pcValue),
        .accValue (accValue),
        .rdData   (rdData),
        .rdReq    (rdReq),
        .rdAddr   (rdAddr),
        .wrReq    (wrReq),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rdWord   (rdWord),
        .iszSkip  (iszSkip)
    );

endmodule

// ==== dv/execUnitModel.svh ====
// Reference model of the execution unit state and per-instruction predictions
`ifndef EXECUNITMODEL_SVH
`define EXECUNITMODEL_SVH

logic [`DATA_WIDTH-1:0] mMem [0:4095];
logic [`DATA_WIDTH-1:0] mAcc;
logic                   mLink;
logic [`ADDR_WIDTH-1:0] mPc;

// Predictions for the instruction in flight
logic                   expRead;
logic [`ADDR_WIDTH-1:0] expRdAddr;
logic                   expWrite;
logic [`ADDR_WIDTH-1:0] expWrAddr;
logic [`DATA_WIDTH-1:0] expWrData;
int                     expCycles;

// Kind codes 0..7 are AND TAD ISZ DCA JMS JMP NOP CLA_CLL
task automatic modelStep(input int kind, input logic [`ADDR_WIDTH-1:0] addr);
    int                     total;
    logic [`DATA_WIDTH-1:0] word;
    logic [`ADDR_WIDTH-1:0] oldPc;
    oldPc     = mPc;
    word      = mMem[addr];
    expRead   = (kind <= 2);
    expRdAddr = addr;
    expWrite  = 1'b0;
    expWrAddr = addr;
    expWrData = '0;
    expCycles = 3;
    mPc       = oldPc + 12'd1;
    case (kind)
        0: begin
            mAcc      = mAcc & word;
            expCycles = 4;
        end
        1: begin
            // Link flips when the sum leaves the 12-bit range
            total = int'(mAcc) + int'(word);
            mAcc  = total[`DATA_WIDTH-1:0];
            if (total > 4095) begin
                mLink = !mLink;
            end
            expCycles = 4;
        end
        2: begin
            word       = word + 12'd1;
            mMem[addr] = word;
            expWrite   = 1'b1;
            expWrData  = word;
            expCycles  = 5;
            // Wrap to zero skips the next word
            if (word == '0) begin
                mPc = oldPc + 12'd2;
            end
        end
        3: begin
            expWrite   = 1'b1;
            expWrData  = mAcc;
            mMem[addr] = mAcc;
            mAcc       = '0;
        end
        4: begin
            expWrite   = 1'b1;
            expWrData  = oldPc + 12'd1;
            mMem[addr] = oldPc + 12'd1;
            mPc        = addr + 12'd1;
        end
        5: mPc = addr;
        7: begin
            mAcc  = '0;
            mLink = 1'b0;
        end
        default: ;
    endcase
endtask

function automatic string kindName(input int kind);
    string names [8] = '{"AND", "TAD", "ISZ", "DCA", "JMS", "JMP", "NOP", "CLA_CLL"};
    return names[kind];
endfunction

`endif

// ==== dv/execUnitTb.sv ====
// Testbench for the PDP-8 execution unit with memory responder and reference model
`timescale 1ns/1ps
`include "pdp8Exec_consts.svh"

module execUnitTb import pdp8ExecPkg::*; ();

    logic                   clk;
    logic                   reset_n;
    logic [`ADDR_WIDTH-1:0] baseAddr;
    memOpcodeT              memOpcode;
    op7OpcodeT              op7Opcode;
    logic [`DATA_WIDTH-1:0] rdData;
    logic                   stall;
    logic [`ADDR_WIDTH-1:0] pcValue;
    logic                   illegalInstr;
    logic                   rdReq;
    logic [`ADDR_WIDTH-1:0] rdAddr;
    logic                   wrReq;
    logic [`ADDR_WIDTH-1:0] wrAddr;
    logic [`DATA_WIDTH-1:0] wrData;
    logic [`DATA_WIDTH-1:0] accValue;
    logic                   linkValue;

    logic [`DATA_WIDTH-1:0] mem [0:4095];
    int errors;
    int testNum;
    int rdSeen;
    int wrSeen;

    `include "execUnitModel.svh"

    execUnitTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [`DATA_WIDTH-1:0] expV,
                              input logic [`DATA_WIDTH-1:0] actV);
        if (expV !== actV) begin
            $display("MISMATCH t=%0t %s expected=%o actual=%o", $time, name, expV, actV);
            errors++;
        end
    endtask

    // Memory answers a read one cycle later and takes writes on the request edge
    always @(posedge clk) begin
        if (rdReq) begin
            rdData <= mem[rdAddr];
            rdSeen++;
            checkValue("rdAddr", expRdAddr, rdAddr);
        end
        if (wrReq) begin
            mem[wrAddr] <= wrData;
            wrSeen++;
            checkValue("wrAddr", expWrAddr, wrAddr);
            checkValue("wrData", expWrData, wrData);
        end
    end

    function automatic memOpcodeT encodeMem(input int kind, input logic [`ADDR_WIDTH-1:0] addr);
        memOpcodeT m;
        m = '0;
        m.memAddr = addr;
        case (kind)
            0: m.opAnd = 1'b1;
            1: m.opTad = 1'b1;
            2: m.opIsz = 1'b1;
            3: m.opDca = 1'b1;
            4: m.opJms = 1'b1;
            5: m.opJmp = 1'b1;
            default: m.memAddr = '0;
        endcase
        return m;
    endfunction

    task automatic runInstr(input int kind, input logic [`ADDR_WIDTH-1:0] addr);
        int cyc;
        int errBefore;
        int rdBefore;
        int wrBefore;
        errBefore = errors;
        rdBefore  = rdSeen;
        wrBefore  = wrSeen;
        modelStep(kind, addr);
        @(posedge clk);
        memOpcode     <= encodeMem(kind, addr);
        op7Opcode     <= '0;
        op7Opcode.nop <= (kind == 6);
        op7Opcode.claCll <= (kind == 7);
        // This edge accepts the instruction
        @(posedge clk);
        memOpcode <= '0;
        op7Opcode <= '0;
        cyc = 0;
        @(negedge clk);
        while (stall && cyc <= 10) begin
            cyc++;
            @(negedge clk);
        end
        if (cyc > 10) begin
            $display("Timeout: stall stayed high after %s", kindName(kind));
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            if (cyc != expCycles) begin
                $display("MISMATCH t=%0t stallCycles expected=%0d actual=%0d",
                         $time, expCycles, cyc);
                errors++;
            end
            checkValue("pcValue", mPc, pcValue);
            checkValue("accValue", mAcc, accValue);
            checkValue("linkValue", `DATA_WIDTH'(mLink), `DATA_WIDTH'(linkValue));
            if ((rdSeen - rdBefore) != int'(expRead) ||
                (wrSeen - wrBefore) != int'(expWrite)) begin
                $display("Wrong number of memory requests for %s", kindName(kind));
                errors++;
            end
            testNum++;
            $display("test %0d %s addr=%o %s", testNum, kindName(kind), addr,
                     (errors == errBefore) ? "ok" : "FAILED");
        end
    endtask

    initial begin
        int                     savedWr;
        int                     errBefore;
        void'($urandom(32'hb96e));
        reset_n   = 1'b0;
        baseAddr  = `START_ADDRESS;
        memOpcode = '0;
        op7Opcode = '0;
        rdData    = '0;
        errors    = 0;
        testNum   = 0;
        rdSeen    = 0;
        wrSeen    = 0;
        for (int i = 0; i < 4096; i++) begin
            mem[i]  = 12'($urandom);
            mMem[i] = mem[i];
        end
        mAcc  = '0;
        mLink = 1'b0;
        mPc   = `START_ADDRESS;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        @(negedge clk);
        errBefore = errors;
        checkValue("stall", 12'd0, `DATA_WIDTH'(stall));
        checkValue("rdReq", 12'd0, `DATA_WIDTH'(rdReq));
        checkValue("wrReq", 12'd0, `DATA_WIDTH'(wrReq));
        checkValue("illegalInstr", 12'd0, `DATA_WIDTH'(illegalInstr));
        checkValue("accValue", 12'd0, accValue);
        checkValue("linkValue", 12'd0, `DATA_WIDTH'(linkValue));
        checkValue("pcValue", `START_ADDRESS, pcValue);
        testNum++;
        $display("test %0d reset state %s", testNum, (errors == errBefore) ? "ok" : "FAILED");

        for (int n = 0; n < 200; n++) begin
            runInstr($urandom_range(7, 0), 12'($urandom));
        end

        // ISZ wrapping from 7777 and ISZ on an ordinary word
        mem[12'o1234]  = 12'o7777;
        mMem[12'o1234] = 12'o7777;
        runInstr(2, 12'o1234);
        checkValue("mem[1234]", 12'o0000, mem[12'o1234]);
        mem[12'o1235]  = 12'o0041;
        mMem[12'o1235] = 12'o0041;
        runInstr(2, 12'o1235);

        // DCA and JMS at once, watched for longer than any instruction takes
        errBefore = errors;
        savedWr   = wrSeen;
        @(posedge clk);
        memOpcode       <= encodeMem(3, 12'o0100);
        memOpcode.opJms <= 1'b1;
        @(posedge clk);
        memOpcode <= '0;
        @(negedge clk);
        checkValue("illegalInstr", 12'd1, `DATA_WIDTH'(illegalInstr));
        checkValue("stall", 12'd0, `DATA_WIDTH'(stall));
        for (int c = 0; c <= `CYCLES_ISZ; c++) begin
            @(negedge clk);
            checkValue("illegalInstr", 12'd0, `DATA_WIDTH'(illegalInstr));
            checkValue("stall", 12'd0, `DATA_WIDTH'(stall));
        end
        checkValue("pcValue", mPc, pcValue);
        checkValue("accValue", mAcc, accValue);
        checkValue("linkValue", `DATA_WIDTH'(mLink), `DATA_WIDTH'(linkValue));
        if (wrSeen != savedWr) begin
            $display("Illegal instruction wrote to memory");
            errors++;
        end
        testNum++;
        $display("test %0d illegal opcode %s", testNum, (errors == errBefore) ? "ok" : "FAILED");

        $display("tests run %0d, errors %0d", testNum, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
+incdir+dv
design/pdp8ExecPkg.sv
design/execSequencer.sv
design/accumulatorUnit.sv
design/memoryAccess.sv
design/execUnitTop.sv
dv/execUnitTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = execUnitTb
FILELIST = filelist.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SRCS     = $(wildcard design/*.sv design/*.svh dv/*.sv dv/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Output goes to the terminal, the exit status comes from grep
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf $(OBJDIR)
